//--- source/best_price_scan.sv
`timescale 1ns/1ps
// ######################################
// sequential best price search
// ######################################
module best_price_scan #(
    parameter int NUM_STOCKS   = 4,
    parameter int BOOK_DEPTH   = 8,
    parameter bit PICK_HIGHEST = 1,
    localparam int SW = $clog2(NUM_STOCKS),
    localparam int CW = $clog2(BOOK_DEPTH + 1),
    localparam int IW = $clog2(BOOK_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic [SW-1:0]      i_stock,
    input  logic               i_start,
    input  logic [CW-1:0]      i_count,
    input  ob_cfg_pkg::price_t i_read_price,
    output logic [IW-1:0]      o_read_slot,
    output logic               o_done,
    output ob_cfg_pkg::price_t o_best
);
    ob_cfg_pkg::price_t best_mem [NUM_STOCKS];
    ob_cfg_pkg::price_t acc;
    logic [CW-1:0]      idx;
    logic               running;
    logic               take;

    assign o_read_slot = idx[IW-1:0];
    assign o_done      = running && (idx == i_count);
    assign o_best      = best_mem[i_stock];

    // slot 0 seeds the running extreme
    always_comb begin
        if (idx == '0) take = 1'b1;
        else if (PICK_HIGHEST) take = (i_read_price > acc);
        else take = (i_read_price < acc);
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            running <= 1'b0;
            for (int k = 0; k < NUM_STOCKS; k++) begin
                best_mem[k] <= '0;
            end
        end else if (i_start) begin
            running <= 1'b1;
        end else if (o_done) begin
            // empty side leaves acc at zero
            running           <= 1'b0;
            best_mem[i_stock] <= acc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            idx <= '0;
            acc <= '0;
        end else if (running && !o_done) begin
            idx <= idx + 1'b1;
            if (take) acc <= i_read_price;
        end
    end

endmodule

//--- source/ob_cfg_pkg.sv
// ######################################
// book sizing defaults and payload widths
// ######################################
package ob_cfg_pkg;

    // stocks tracked by one book
    localparam int NUM_STOCKS_DEF = 4;
    // resting orders per stock on each side
    localparam int BOOK_DEPTH_DEF = 8;

    typedef logic [31:0] price_t;
    typedef logic [15:0] qty_t;
    typedef logic [31:0] order_id_t;

endpackage

//--- source/ob_msg_pkg.sv
// ######################################
// order kind and side encodings
// controller state encoding
// ######################################
package ob_msg_pkg;

    // code 3 never names a valid kind
    typedef enum logic [1:0] {
        ADD     = 2'd0,
        CANCEL  = 2'd1,
        EXECUTE = 2'd2
    } order_kind_e;

    // sell rests on the ask side, buy on the bid side
    typedef enum logic {
        SELL = 1'b0,
        BUY  = 1'b1
    } side_e;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        APPLY   = 3'd1,
        REMOVE  = 3'd2,
        SCAN    = 3'd3,
        PRESENT = 3'd4
    } ctrl_state_e;

endpackage

//--- source/order_book_ctrl.sv
`timescale 1ns/1ps
// ######################################
// order sequencing FSM with last prices
// and the quote output
// ######################################
module order_book_ctrl #(
    parameter int NUM_STOCKS = 4,
    localparam int SW = $clog2(NUM_STOCKS)
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_order_valid,
    input  ob_msg_pkg::order_kind_e i_kind,
    input  ob_msg_pkg::side_e       i_side,
    input  logic [SW-1:0]           i_stock,
    input  ob_cfg_pkg::qty_t        i_qty,
    input  ob_cfg_pkg::price_t      i_price,
    input  ob_cfg_pkg::order_id_t   i_order_id,
    input  logic                    i_consumer_ready,
    input  logic                    i_bid_hit,
    input  logic                    i_ask_hit,
    input  ob_cfg_pkg::qty_t        i_bid_hit_qty,
    input  ob_cfg_pkg::qty_t        i_ask_hit_qty,
    input  ob_cfg_pkg::price_t      i_bid_hit_price,
    input  ob_cfg_pkg::price_t      i_ask_hit_price,
    input  logic                    i_bid_full,
    input  logic                    i_ask_full,
    input  logic                    i_bid_remove_done,
    input  logic                    i_ask_remove_done,
    input  logic                    i_bid_scan_done,
    input  logic                    i_ask_scan_done,
    input  ob_cfg_pkg::price_t      i_bid_best,
    input  ob_cfg_pkg::price_t      i_ask_best,
    output logic [SW-1:0]           o_stock,
    output ob_cfg_pkg::order_id_t   o_order_id,
    output ob_cfg_pkg::qty_t        o_qty,
    output ob_cfg_pkg::price_t      o_price,
    output logic                    o_bid_append,
    output logic                    o_ask_append,
    output logic                    o_bid_decrement,
    output logic                    o_ask_decrement,
    output logic                    o_bid_remove,
    output logic                    o_ask_remove,
    output logic                    o_bid_scan_start,
    output logic                    o_ask_scan_start,
    output logic                    o_book_busy,
    output logic                    o_quote_valid,
    output ob_cfg_pkg::price_t      o_best_bid,
    output ob_cfg_pkg::price_t      o_best_ask,
    output ob_cfg_pkg::price_t      o_last_price,
    output logic                    o_reject
);
    ob_msg_pkg::ctrl_state_e state, next_state;
    ob_msg_pkg::order_kind_e kind_q;
    ob_msg_pkg::side_e       side_q;
    ob_cfg_pkg::price_t      last_price [NUM_STOCKS];
    ob_cfg_pkg::price_t      last_val;
    ob_cfg_pkg::price_t      sel_price;
    ob_cfg_pkg::qty_t        sel_qty;
    logic is_buy, sel_hit, sel_full, sel_remove_done, sel_scan_done;
    logic do_append, do_decrement, do_remove, do_reject, do_last;
    logic scan_start_q;
    logic reject_q;

    // everything after acceptance goes to the side named in the order
    assign is_buy          = (side_q == ob_msg_pkg::BUY);
    assign sel_hit         = is_buy ? i_bid_hit : i_ask_hit;
    assign sel_qty         = is_buy ? i_bid_hit_qty : i_ask_hit_qty;
    assign sel_price       = is_buy ? i_bid_hit_price : i_ask_hit_price;
    assign sel_full        = is_buy ? i_bid_full : i_ask_full;
    assign sel_remove_done = is_buy ? i_bid_remove_done : i_ask_remove_done;
    assign sel_scan_done   = is_buy ? i_bid_scan_done : i_ask_scan_done;

    // accept or reject, decided from the lookup in APPLY
    always_comb begin
        do_append    = 1'b0;
        do_decrement = 1'b0;
        do_remove    = 1'b0;
        do_reject    = 1'b0;
        do_last      = 1'b0;
        last_val     = o_price;
        if (state == ob_msg_pkg::APPLY) begin
            case (kind_q)
                ob_msg_pkg::ADD: begin
                    do_reject = sel_full;
                    do_append = !sel_full;
                    do_last   = !sel_full;
                end
                ob_msg_pkg::CANCEL: begin
                    do_reject = !sel_hit;
                    do_remove = sel_hit;
                end
                ob_msg_pkg::EXECUTE: begin
                    if (!sel_hit || o_qty > sel_qty) begin
                        do_reject = 1'b1;
                    end else begin
                        // trades at the resting price
                        do_last      = 1'b1;
                        last_val     = sel_price;
                        do_remove    = (o_qty == sel_qty);
                        do_decrement = (o_qty != sel_qty);
                    end
                end
                default: do_reject = 1'b1;
            endcase
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ob_msg_pkg::IDLE: begin
                if (i_order_valid) next_state = ob_msg_pkg::APPLY;
            end
            ob_msg_pkg::APPLY: begin
                if (do_reject) next_state = ob_msg_pkg::PRESENT;
                else if (do_remove) next_state = ob_msg_pkg::REMOVE;
                else next_state = ob_msg_pkg::SCAN;
            end
            ob_msg_pkg::REMOVE: begin
                if (sel_remove_done) next_state = ob_msg_pkg::SCAN;
            end
            ob_msg_pkg::SCAN: begin
                if (sel_scan_done) next_state = ob_msg_pkg::PRESENT;
            end
            ob_msg_pkg::PRESENT: begin
                if (i_consumer_ready) next_state = ob_msg_pkg::IDLE;
            end
            default: next_state = ob_msg_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state        <= ob_msg_pkg::IDLE;
            o_stock      <= '0;
            scan_start_q <= 1'b0;
            reject_q     <= 1'b0;
            for (int k = 0; k < NUM_STOCKS; k++) begin
                last_price[k] <= '0;
            end
        end else begin
            state        <= next_state;
            scan_start_q <= (next_state == ob_msg_pkg::SCAN) && (state != ob_msg_pkg::SCAN);
            if (state == ob_msg_pkg::IDLE && i_order_valid) o_stock <= i_stock;
            if (state == ob_msg_pkg::APPLY) reject_q <= do_reject;
            if (do_last) last_price[o_stock] <= last_val;
        end
    end

    // order fields, sampled only at acceptance
    always_ff @(posedge i_clk) begin
        if (state == ob_msg_pkg::IDLE && i_order_valid) begin
            kind_q     <= i_kind;
            side_q     <= i_side;
            o_order_id <= i_order_id;
            o_qty      <= i_qty;
            o_price    <= i_price;
        end
    end

    assign o_bid_append     = do_append && is_buy;
    assign o_ask_append     = do_append && !is_buy;
    assign o_bid_decrement  = do_decrement && is_buy;
    assign o_ask_decrement  = do_decrement && !is_buy;
    assign o_bid_remove     = do_remove && is_buy;
    assign o_ask_remove     = do_remove && !is_buy;
    assign o_bid_scan_start = scan_start_q && is_buy;
    assign o_ask_scan_start = scan_start_q && !is_buy;

    assign o_book_busy   = (state != ob_msg_pkg::IDLE);
    assign o_quote_valid = (state == ob_msg_pkg::PRESENT);
    // quote fields hold still while PRESENT since the stock is latched
    assign o_best_bid    = i_bid_best;
    assign o_best_ask    = i_ask_best;
    assign o_last_price  = last_price[o_stock];
    assign o_reject      = reject_q;

endmodule

//--- source/order_book_top.sv
`timescale 1ns/1ps
// ######################################
// order book top level
// controller, bid and ask books, scanners
// ######################################
module order_book_top #(
    parameter int NUM_STOCKS = ob_cfg_pkg::NUM_STOCKS_DEF,
    parameter int BOOK_DEPTH = ob_cfg_pkg::BOOK_DEPTH_DEF,
    localparam int SW = $clog2(NUM_STOCKS)
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_order_valid,
    input  ob_msg_pkg::order_kind_e i_kind,
    input  ob_msg_pkg::side_e       i_side,
    input  logic [SW-1:0]           i_stock,
    input  ob_cfg_pkg::qty_t        i_qty,
    input  ob_cfg_pkg::price_t      i_price,
    input  ob_cfg_pkg::order_id_t   i_order_id,
    input  logic                    i_consumer_ready,
    output logic                    o_book_busy,
    output logic                    o_quote_valid,
    output ob_cfg_pkg::price_t      o_best_bid,
    output ob_cfg_pkg::price_t      o_best_ask,
    output ob_cfg_pkg::price_t      o_last_price,
    output logic                    o_reject
);
    localparam int CW = $clog2(BOOK_DEPTH + 1);
    localparam int IW = $clog2(BOOK_DEPTH);

    logic [SW-1:0]         stock_q;
    ob_cfg_pkg::order_id_t id_q;
    ob_cfg_pkg::qty_t      qty_q;
    ob_cfg_pkg::price_t    price_q;
    logic                  bid_append, ask_append, bid_decrement, ask_decrement;
    logic                  bid_remove, ask_remove, bid_remove_done, ask_remove_done;
    logic                  bid_hit, ask_hit, bid_full, ask_full;
    ob_cfg_pkg::qty_t      bid_hit_qty, ask_hit_qty;
    ob_cfg_pkg::price_t    bid_hit_price, ask_hit_price;
    logic                  bid_scan_start, ask_scan_start, bid_scan_done, ask_scan_done;
    ob_cfg_pkg::price_t    bid_best, ask_best, bid_read_price, ask_read_price;
    logic [CW-1:0]         bid_count, ask_count;
    logic [IW-1:0]         bid_read_slot, ask_read_slot;

    order_book_ctrl #(.NUM_STOCKS(NUM_STOCKS)) ctrl (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_order_valid(i_order_valid),
        .i_kind(i_kind), .i_side(i_side), .i_stock(i_stock), .i_qty(i_qty),
        .i_price(i_price), .i_order_id(i_order_id), .i_consumer_ready(i_consumer_ready),
        .i_bid_hit(bid_hit), .i_ask_hit(ask_hit),
        .i_bid_hit_qty(bid_hit_qty), .i_ask_hit_qty(ask_hit_qty),
        .i_bid_hit_price(bid_hit_price), .i_ask_hit_price(ask_hit_price),
        .i_bid_full(bid_full), .i_ask_full(ask_full),
        .i_bid_remove_done(bid_remove_done), .i_ask_remove_done(ask_remove_done),
        .i_bid_scan_done(bid_scan_done), .i_ask_scan_done(ask_scan_done),
        .i_bid_best(bid_best), .i_ask_best(ask_best),
        .o_stock(stock_q), .o_order_id(id_q), .o_qty(qty_q), .o_price(price_q),
        .o_bid_append(bid_append), .o_ask_append(ask_append),
        .o_bid_decrement(bid_decrement), .o_ask_decrement(ask_decrement),
        .o_bid_remove(bid_remove), .o_ask_remove(ask_remove),
        .o_bid_scan_start(bid_scan_start), .o_ask_scan_start(ask_scan_start),
        .o_book_busy(o_book_busy), .o_quote_valid(o_quote_valid),
        .o_best_bid(o_best_bid), .o_best_ask(o_best_ask),
        .o_last_price(o_last_price), .o_reject(o_reject)
    );

    side_book #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) bid_book (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock(stock_q), .i_order_id(id_q),
        .i_qty(qty_q), .i_price(price_q), .i_append(bid_append),
        .i_decrement(bid_decrement), .i_remove(bid_remove), .i_read_slot(bid_read_slot),
        .o_hit(bid_hit), .o_hit_qty(bid_hit_qty), .o_hit_price(bid_hit_price),
        .o_full(bid_full), .o_count(bid_count), .o_read_price(bid_read_price),
        .o_remove_done(bid_remove_done)
    );

    side_book #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) ask_book (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock(stock_q), .i_order_id(id_q),
        .i_qty(qty_q), .i_price(price_q), .i_append(ask_append),
        .i_decrement(ask_decrement), .i_remove(ask_remove), .i_read_slot(ask_read_slot),
        .o_hit(ask_hit), .o_hit_qty(ask_hit_qty), .o_hit_price(ask_hit_price),
        .o_full(ask_full), .o_count(ask_count), .o_read_price(ask_read_price),
        .o_remove_done(ask_remove_done)
    );

    // bid keeps the highest price, ask the lowest
    best_price_scan #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH), .PICK_HIGHEST(1))
    bid_scan (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock(stock_q),
        .i_start(bid_scan_start), .i_count(bid_count), .i_read_price(bid_read_price),
        .o_read_slot(bid_read_slot), .o_done(bid_scan_done), .o_best(bid_best)
    );

    best_price_scan #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH), .PICK_HIGHEST(0))
    ask_scan (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock(stock_q),
        .i_start(ask_scan_start), .i_count(ask_count), .i_read_price(ask_read_price),
        .o_read_slot(ask_read_slot), .o_done(ask_scan_done), .o_best(ask_best)
    );

endmodule

//--- source/side_book.sv
`timescale 1ns/1ps
// ######################################
// one side of the book, slots per stock
// ######################################
module side_book #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    localparam int SW = $clog2(NUM_STOCKS),
    localparam int CW = $clog2(BOOK_DEPTH + 1),
    localparam int IW = $clog2(BOOK_DEPTH)
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic [SW-1:0]         i_stock,
    input  ob_cfg_pkg::order_id_t i_order_id,
    input  ob_cfg_pkg::qty_t      i_qty,
    input  ob_cfg_pkg::price_t    i_price,
    input  logic                  i_append,
    input  logic                  i_decrement,
    input  logic                  i_remove,
    input  logic [IW-1:0]         i_read_slot,
    output logic                  o_hit,
    output ob_cfg_pkg::qty_t      o_hit_qty,
    output ob_cfg_pkg::price_t    o_hit_price,
    output logic                  o_full,
    output logic [CW-1:0]         o_count,
    output ob_cfg_pkg::price_t    o_read_price,
    output logic                  o_remove_done
);
    ob_cfg_pkg::qty_t      qty_mem   [NUM_STOCKS][BOOK_DEPTH];
    ob_cfg_pkg::price_t    price_mem [NUM_STOCKS][BOOK_DEPTH];
    ob_cfg_pkg::order_id_t id_mem    [NUM_STOCKS][BOOK_DEPTH];
    logic [CW-1:0]         count     [NUM_STOCKS];
    logic [CW-1:0]         cur_count;
    logic [IW-1:0]         hit_slot;
    logic [IW-1:0]         rm_slot;
    logic                  rm_busy;
    logic                  rm_last;

    assign cur_count    = count[i_stock];
    assign o_count      = cur_count;
    assign o_full       = (cur_count == CW'(BOOK_DEPTH));
    assign o_read_price = price_mem[i_stock][i_read_slot];

    // walk down so the lowest matching slot is the one kept
    always_comb begin
        o_hit    = 1'b0;
        hit_slot = '0;
        for (int s = BOOK_DEPTH - 1; s >= 0; s--) begin
            if (s < cur_count && id_mem[i_stock][s] == i_order_id) begin
                o_hit    = 1'b1;
                hit_slot = IW'(s);
            end
        end
    end

    assign o_hit_qty   = qty_mem[i_stock][hit_slot];
    assign o_hit_price = price_mem[i_stock][hit_slot];

    // last removal cycle once nothing is left above the slot being filled
    assign rm_last       = rm_busy && (rm_slot + 1 >= cur_count - 1);
    assign o_remove_done = rm_last;

    always_ff @(posedge i_clk) begin
        if (i_append) begin
            qty_mem[i_stock][cur_count[IW-1:0]]   <= i_qty;
            price_mem[i_stock][cur_count[IW-1:0]] <= i_price;
            id_mem[i_stock][cur_count[IW-1:0]]    <= i_order_id;
        end
        if (i_decrement) begin
            qty_mem[i_stock][hit_slot] <= o_hit_qty - i_qty;
        end
        if (i_remove) begin
            rm_slot <= hit_slot;
        end else if (rm_busy && !rm_last) begin
            rm_slot <= rm_slot + 1'b1;
        end
        if (rm_busy) begin
            // pull the next entry down one slot
            if (rm_slot + 1 < cur_count) begin
                qty_mem[i_stock][rm_slot]   <= qty_mem[i_stock][rm_slot + 1];
                price_mem[i_stock][rm_slot] <= price_mem[i_stock][rm_slot + 1];
                id_mem[i_stock][rm_slot]    <= id_mem[i_stock][rm_slot + 1];
            end
            if (rm_last) begin
                qty_mem[i_stock][cur_count - 1]   <= '0;
                price_mem[i_stock][cur_count - 1] <= '0;
                id_mem[i_stock][cur_count - 1]    <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            rm_busy <= 1'b0;
            for (int k = 0; k < NUM_STOCKS; k++) begin
                count[k] <= '0;
            end
        end else begin
            if (i_append) count[i_stock] <= cur_count + 1'b1;
            if (i_remove) rm_busy <= 1'b1;
            if (rm_last) begin
                rm_busy        <= 1'b0;
                count[i_stock] <= cur_count - 1'b1;
            end
        end
    end

endmodule

//--- verification/order_book_asserts.sv
`timescale 1ns/1ps
// ######################################
// handshake and quote assertions
// ######################################
module order_book_asserts (
    input logic               i_clk,
    input logic               i_reset_n,
    input logic               i_order_valid,
    input logic               i_consumer_ready,
    input logic               i_book_busy,
    input logic               i_quote_valid,
    input ob_cfg_pkg::price_t i_best_bid,
    input ob_cfg_pkg::price_t i_best_ask,
    input ob_cfg_pkg::price_t i_last_price,
    input logic               i_reject
);
    int fail_count = 0;

    quote_needs_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_quote_valid |-> i_book_busy)
        else begin
            fail_count++;
            $error("quote valid while the book is idle");
        end

    // held quote must not move
    quote_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_quote_valid && !i_consumer_ready |=> i_quote_valid && $stable(i_best_bid)
            && $stable(i_best_ask) && $stable(i_last_price) && $stable(i_reject))
        else begin
            fail_count++;
            $error("quote changed or dropped before the consumer was ready");
        end

    // busy holds until the quote is taken, so nothing new starts meanwhile
    busy_holds: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_book_busy && !(i_quote_valid && i_consumer_ready) |=> i_book_busy)
        else begin
            fail_count++;
            $error("book went idle before its quote was taken");
        end

    accept_sets_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_order_valid && !i_book_busy |=> i_book_busy)
        else begin
            fail_count++;
            $error("order offered to an idle book was not taken");
        end

    quote_drops: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_quote_valid && i_consumer_ready |=> !i_quote_valid)
        else begin
            fail_count++;
            $error("quote still valid after the consumer took it");
        end

endmodule

bind order_book_top order_book_asserts asserts0 (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_order_valid(i_order_valid),
    .i_consumer_ready(i_consumer_ready), .i_book_busy(o_book_busy),
    .i_quote_valid(o_quote_valid), .i_best_bid(o_best_bid), .i_best_ask(o_best_ask),
    .i_last_price(o_last_price), .i_reject(o_reject)
);

//--- verification/order_book_stim.svh
// ######################################
// quote table rows for the order book
// ######################################
// name, kind (0 add, 1 cancel, 2 execute), side (1 buy, 0 sell), stock, qty, price, id
// then expected best bid, best ask, last price, reject
add_row("add_bid_1000",      0, 1, 0, 100, 1000,   1, 1000,    0, 1000, 0);
add_row("add_bid_1020",      0, 1, 0,  50, 1020,   2, 1020,    0, 1020, 0);
add_row("add_ask_1050",      0, 0, 0,  70, 1050,   3, 1020, 1050, 1050, 0);
add_row("add_ask_1040",      0, 0, 0,  40, 1040,   4, 1020, 1040, 1040, 0);
add_row("add_bid_1010",      0, 1, 0,  30, 1010,   5, 1020, 1040, 1010, 0);
add_row("add_ask_1060",      0, 0, 0,  20, 1060,   6, 1020, 1040, 1060, 0);
// stock 2 has its own book and last price
add_row("s2_add_bid",        0, 1, 2,  10,  500,  20,  500,    0,  500, 0);
add_row("s2_add_ask",        0, 0, 2,  10,  520,  21,  500,  520,  520, 0);
add_row("cancel_best_bid",   1, 1, 0,   0,    0,   2, 1010, 1040, 1060, 0);
add_row("cancel_unknown_id", 1, 1, 0,   0,    0, 999, 1010, 1040, 1060, 1);
// executes trade at the resting price
add_row("exec_partial",      2, 0, 0,  15,    0,   4, 1010, 1040, 1040, 0);
add_row("exec_over_qty",     2, 0, 0,  30,    0,   4, 1010, 1040, 1040, 1);
add_row("exec_remainder",    2, 0, 0,  25,    0,   4, 1010, 1050, 1040, 0);
add_row("s2_exec_bid",       2, 1, 2,   4,    0,  20,  500,  520,  500, 0);
// fill the ask side of stock 1
add_row("fill_ask_0",        0, 0, 1,  10, 2000, 100,    0, 2000, 2000, 0);
add_row("fill_ask_1",        0, 0, 1,  10, 1990, 101,    0, 1990, 1990, 0);
add_row("fill_ask_2",        0, 0, 1,  10, 2010, 102,    0, 1990, 2010, 0);
add_row("fill_ask_3",        0, 0, 1,  10, 1980, 103,    0, 1980, 1980, 0);
add_row("fill_ask_4",        0, 0, 1,  10, 2020, 104,    0, 1980, 2020, 0);
add_row("fill_ask_5",        0, 0, 1,  10, 1985, 105,    0, 1980, 1985, 0);
add_row("fill_ask_6",        0, 0, 1,  10, 2030, 106,    0, 1980, 2030, 0);
add_row("fill_ask_7",        0, 0, 1,  10, 1995, 107,    0, 1980, 1995, 0);
add_row("add_full_reject",   0, 0, 1,  10, 1970, 108,    0, 1980, 1995, 1);
add_row("cancel_mid_ask",    1, 0, 1,   0,    0, 103,    0, 1985, 1995, 0);
add_row("add_after_cancel",  0, 0, 1,  10, 1970, 108,    0, 1970, 1970, 0);
add_row("cancel_first_ask",  1, 0, 1,   0,    0, 100,    0, 1970, 1970, 0);

//--- verification/order_book_tb.sv
`timescale 1ns/1ps
// ######################################
// order book testbench, table driven
// with random consumer back-pressure
// ######################################
module order_book_tb;

    localparam int NUM_STOCKS = ob_cfg_pkg::NUM_STOCKS_DEF;
    localparam int BOOK_DEPTH = ob_cfg_pkg::BOOK_DEPTH_DEF;
    localparam int SW = $clog2(NUM_STOCKS);

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    order_valid;
    ob_msg_pkg::order_kind_e kind;
    ob_msg_pkg::side_e       side;
    logic [SW-1:0]           stock;
    ob_cfg_pkg::qty_t        qty;
    ob_cfg_pkg::price_t      price;
    ob_cfg_pkg::order_id_t   order_id;
    logic                    consumer_ready;
    logic                    book_busy;
    logic                    quote_valid;
    ob_cfg_pkg::price_t      best_bid;
    ob_cfg_pkg::price_t      best_ask;
    ob_cfg_pkg::price_t      last_price;
    logic                    reject;

    // one entry per row of the stimulus table
    string name_tab  [$];
    int    kind_tab  [$];
    int    side_tab  [$];
    int    stock_tab [$];
    int    qty_tab   [$];
    int    price_tab [$];
    int    id_tab    [$];
    int    bid_tab   [$];
    int    ask_tab   [$];
    int    last_tab  [$];
    int    rej_tab   [$];

    int          error_count = 0;
    int          check_count = 0;
    int          row_idx = 0;
    bit          table_ready = 1'b0;
    logic [15:0] lfsr = 16'd11;

    always #10 clk = ~clk;

    order_book_top #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) dut0 (
        .i_clk(clk), .i_reset_n(reset_n), .i_order_valid(order_valid),
        .i_kind(kind), .i_side(side), .i_stock(stock), .i_qty(qty),
        .i_price(price), .i_order_id(order_id), .i_consumer_ready(consumer_ready),
        .o_book_busy(book_busy), .o_quote_valid(quote_valid),
        .o_best_bid(best_bid), .o_best_ask(best_ask),
        .o_last_price(last_price), .o_reject(reject)
    );

    task automatic add_row(input string nm, input int k, input int sd, input int st,
                           input int q, input int p, input int id, input int eb,
                           input int ea, input int el, input int er);
        name_tab.push_back(nm);
        kind_tab.push_back(k);
        side_tab.push_back(sd);
        stock_tab.push_back(st);
        qty_tab.push_back(q);
        price_tab.push_back(p);
        id_tab.push_back(id);
        bid_tab.push_back(eb);
        ask_tab.push_back(ea);
        last_tab.push_back(el);
        rej_tab.push_back(er);
    endtask

    task automatic load_table;
        `include "order_book_stim.svh"
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("mismatch %s %s: expected %0d, actual %0d", test, field, expected, actual);
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // two bits give a stall of 0 to 3 cycles
    task automatic pick_delay(output int cycles);
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            cycles = cycles | (int'(lfsr[0]) << b);
        end
    endtask

    task automatic apply_row(input int n);
        int stall;
        while (book_busy) @(negedge clk);
        order_valid = 1'b1;
        kind        = ob_msg_pkg::order_kind_e'(kind_tab[n]);
        side        = ob_msg_pkg::side_e'(side_tab[n]);
        stock       = SW'(stock_tab[n]);
        qty         = ob_cfg_pkg::qty_t'(qty_tab[n]);
        price       = ob_cfg_pkg::price_t'(price_tab[n]);
        order_id    = ob_cfg_pkg::order_id_t'(id_tab[n]);
        @(negedge clk);
        order_valid = 1'b0;
        while (!quote_valid) @(negedge clk);
        pick_delay(stall);
        repeat (stall) @(negedge clk);
        check_value(name_tab[n], "best bid", bid_tab[n], best_bid);
        check_value(name_tab[n], "best ask", ask_tab[n], best_ask);
        check_value(name_tab[n], "last price", last_tab[n], last_price);
        check_value(name_tab[n], "reject", rej_tab[n], reject);
        consumer_ready = 1'b1;
        @(negedge clk);
        consumer_ready = 1'b0;
    endtask

    initial begin
        reset_n        = 1'b0;
        order_valid    = 1'b0;
        kind           = ob_msg_pkg::ADD;
        side           = ob_msg_pkg::SELL;
        stock          = '0;
        qty            = '0;
        price          = '0;
        order_id       = '0;
        consumer_ready = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        for (int n = 0; n < name_tab.size(); n++) begin
            row_idx = n;
            apply_row(n);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, dut0.asserts0.fail_count);
        if (error_count == 0 && dut0.asserts0.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // worst row is a full removal plus a full scan and a stall
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = name_tab.size() * (2 * BOOK_DEPTH + 12) + 10;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, stuck on row %0d of %0d",
                 limit, row_idx, name_tab.size());
        $display("Something failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verification
source/ob_cfg_pkg.sv
source/ob_msg_pkg.sv
source/side_book.sv
source/best_price_scan.sv
source/order_book_ctrl.sv
source/order_book_top.sv
verification/order_book_asserts.sv
verification/order_book_tb.sv
